// File: Bender.yml
package:
  name: tl_core

sources:
  - logic/tl_pkg.sv
  - logic/tl_req_builder.sv
  - logic/tl_tag_table.sv
  - logic/tl_cpl_decoder.sv
  - logic/tl_top.sv
  - target: simulation
    files:
      - verif/tl_asserts.sv
      - verif/tl_tb.sv

// File: logic/tl_cpl_decoder.sv
module tl_cpl_decoder
  import tl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,

  // Link receive
  input  tl_hdr_u          tl_rx_i,
  input  logic             tl_rx_valid_i,
  output logic             tl_rx_ready_o,

  // Tag lookup
  output logic [TAG_W-1:0] lookup_tag_o,
  input  logic [31:0]      lookup_addr_i,
  input  logic             lookup_busy_i,

  // User read return
  output logic [TAG_W-1:0] usr_rtag_o,
  output logic [31:0]      usr_raddr_o,
  output logic [31:0]      usr_rdata_o,
  output logic             usr_rerr_o,
  output logic             usr_rvalid_o,
  input  logic             usr_rready_i,

  // Tag release
  output logic             free_req_o,
  output logic [TAG_W-1:0] free_tag_o
);

  tl_cpl_hdr_s      rx_cpl;
  logic             rx_fire;
  logic             rx_hit;
  logic             rx_err;
  logic             rd_take;
  logic             rvalid_q;
  logic [TAG_W-1:0] rtag_q;
  logic [31:0]      raddr_q;
  logic [31:0]      rdata_q;
  logic             rerr_q;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------

  // Incoming beats are completions, read that view
  assign rx_cpl       = tl_rx_i.cpl;
  assign lookup_tag_o = rx_cpl.tag[TAG_W-1:0];

  // Result register empty or drained this cycle
  assign tl_rx_ready_o = !rvalid_q || usr_rready_i;
  assign rx_fire       = tl_rx_valid_i && tl_rx_ready_o;

  // Stray completions and unknown tags are dropped silently
  assign rx_hit = rx_fire && (rx_cpl.typ == TYPE_CPL) && lookup_busy_i;
  assign rx_err = rx_cpl.status != CPL_STATUS_SC;

  assign rd_take = rvalid_q && usr_rready_i;

  // --------------------------------------------------------------------------
  // Result register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rx_hit) begin
      rvalid_q <= 1'b1;
    end else if (usr_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_hit) begin
      rtag_q  <= lookup_tag_o;
      raddr_q <= lookup_addr_i;
      rerr_q  <= rx_err;
      // Failed completions carry no usable data
      rdata_q <= rx_err ? 32'h0 : rx_cpl.data;
    end
  end

  assign usr_rtag_o   = rtag_q;
  assign usr_raddr_o  = raddr_q;
  assign usr_rdata_o  = rdata_q;
  assign usr_rerr_o   = rerr_q;
  assign usr_rvalid_o = rvalid_q;

  // Tag goes back once the user has the result
  assign free_req_o = rd_take;
  assign free_tag_o = rtag_q;

endmodule

// File: logic/tl_pkg.sv
package tl_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // Tag space of the requester
  localparam int TAG_W    = 3;
  localparam int NUM_TAGS = 8;

  // Fixed bus/device/function of this root port
  localparam logic [15:0] REQUESTER_ID = 16'h0100;

  // --------------------------------------------------------------------------
  // TLP field codes
  // --------------------------------------------------------------------------

  // Fmt, 3DW header without and with a data payload
  localparam logic [2:0] FMT_3DW_NODATA = 3'b000;
  localparam logic [2:0] FMT_3DW_DATA   = 3'b010;

  // Type, memory request and completion
  localparam logic [4:0] TYPE_MEM = 5'b00000;
  localparam logic [4:0] TYPE_CPL = 5'b01010;

  // Completion status, successful completion
  localparam logic [2:0] CPL_STATUS_SC = 3'b000;

  // Length field for a single DW payload
  localparam logic [9:0] LEN_ONE_DW = 10'd1;

  // --------------------------------------------------------------------------
  // Beat layout, 3DW header plus one data DW, DW0 in the top bits
  // --------------------------------------------------------------------------

  // Memory request view
  typedef struct packed {
    logic [2:0]  fmt;
    logic [4:0]  typ;
    logic [13:0] rsvd_dw0;     // TC, attributes, TD, EP, all zero here
    logic [9:0]  length;
    logic [15:0] requester_id;
    logic [7:0]  tag;          // Only the low TAG_W bits are ever nonzero
    logic [3:0]  last_be;
    logic [3:0]  first_be;
    logic [29:0] addr_dw;      // Address bits 31:2
    logic [1:0]  rsvd_ph;
    logic [31:0] data;
  } tl_req_hdr_s;

  // Completion view
  typedef struct packed {
    logic [2:0]  fmt;
    logic [4:0]  typ;
    logic [13:0] rsvd_dw0;
    logic [9:0]  length;
    logic [15:0] completer_id;
    logic [2:0]  status;
    logic        bcm;
    logic [11:0] byte_count;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic        rsvd_dw2;
    logic [6:0]  lower_addr;
    logic [31:0] data;
  } tl_cpl_hdr_s;

  // Fmt and type overlay in both views and select the decode
  typedef union packed {
    tl_req_hdr_s req;
    tl_cpl_hdr_s cpl;
  } tl_hdr_u;

endpackage

// File: logic/tl_req_builder.sv
module tl_req_builder
  import tl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,

  // User command
  input  logic             usr_cmd_write_i,
  input  logic [31:0]      usr_cmd_addr_i,
  input  logic [3:0]       usr_cmd_be_i,
  input  logic [31:0]      usr_cmd_wdata_i,
  input  logic             usr_cmd_valid_i,
  output logic             usr_cmd_ready_o,

  // Link transmit
  output tl_hdr_u          tl_tx_o,
  output logic             tl_tx_valid_o,
  input  logic             tl_tx_ready_i,

  // Tag allocation
  input  logic             alloc_gnt_i,
  input  logic [TAG_W-1:0] alloc_tag_i,
  output logic             alloc_req_o,
  output logic [31:0]      alloc_addr_o
);

  logic    out_valid_q;
  tl_hdr_u out_q;
  tl_hdr_u beat_d;
  logic    slot_free;
  logic    cmd_fire;

  // --------------------------------------------------------------------------
  // Command acceptance
  // --------------------------------------------------------------------------

  // Register empty, or its beat leaves this cycle
  assign slot_free = !out_valid_q || tl_tx_ready_i;

  // Reads also need a free tag
  assign usr_cmd_ready_o = slot_free && (usr_cmd_write_i || alloc_gnt_i);
  assign cmd_fire        = usr_cmd_valid_i && usr_cmd_ready_o;

  // Claim the tag in the acceptance cycle
  assign alloc_req_o  = cmd_fire && !usr_cmd_write_i;
  assign alloc_addr_o = {usr_cmd_addr_i[31:2], 2'b00};

  // --------------------------------------------------------------------------
  // Beat assembly
  // --------------------------------------------------------------------------

  always_comb begin
    beat_d                  = '0;
    beat_d.req.typ          = TYPE_MEM;
    beat_d.req.length       = LEN_ONE_DW;
    beat_d.req.requester_id = REQUESTER_ID;
    // Single DW request, last BE stays zero
    beat_d.req.first_be     = usr_cmd_be_i;
    beat_d.req.addr_dw      = usr_cmd_addr_i[31:2];
    if (usr_cmd_write_i) begin
      // MWr, posted, tag zero
      beat_d.req.fmt  = FMT_3DW_DATA;
      beat_d.req.data = usr_cmd_wdata_i;
    end else begin
      // MRd with the granted tag
      beat_d.req.fmt  = FMT_3DW_NODATA;
      beat_d.req.tag  = 8'(alloc_tag_i);
    end
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (cmd_fire) begin
      out_valid_q <= 1'b1;
    end else if (tl_tx_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Beat data only changes on a new command
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      out_q <= beat_d;
    end
  end

  assign tl_tx_o       = out_q;
  assign tl_tx_valid_o = out_valid_q;

endmodule

// File: logic/tl_tag_table.sv
module tl_tag_table
  import tl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,

  // Allocation from the request side
  input  logic             alloc_req_i,
  input  logic [31:0]      alloc_addr_i,
  output logic             alloc_gnt_o,
  output logic [TAG_W-1:0] alloc_tag_o,

  // Lookup from the completion side
  input  logic [TAG_W-1:0] lookup_tag_i,
  output logic [31:0]      lookup_addr_o,
  output logic             lookup_busy_o,

  // Release from the completion side
  input  logic             free_req_i,
  input  logic [TAG_W-1:0] free_tag_i
);

  logic [NUM_TAGS-1:0] busy_q;
  logic [31:0]         addr_mem [NUM_TAGS];
  logic                alloc_ok;

  // --------------------------------------------------------------------------
  // Lowest free tag
  // --------------------------------------------------------------------------

  // Scan downward so the lowest free index wins
  always_comb begin
    alloc_tag_o = '0;
    for (int i = NUM_TAGS - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        alloc_tag_o = TAG_W'(i);
      end
    end
  end

  assign alloc_gnt_o = ~&busy_q;
  assign alloc_ok    = alloc_req_i && alloc_gnt_o;

  // Combinational lookup
  assign lookup_addr_o = addr_mem[lookup_tag_i];
  assign lookup_busy_o = busy_q[lookup_tag_i];

  // --------------------------------------------------------------------------
  // Busy bits and address store
  // --------------------------------------------------------------------------

  // Freed and allocated tags always differ, both apply
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else begin
      if (free_req_i) begin
        busy_q[free_tag_i] <= 1'b0;
      end
      if (alloc_ok) begin
        busy_q[alloc_tag_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_ok) begin
      addr_mem[alloc_tag_o] <= alloc_addr_i;
    end
  end

endmodule

// File: logic/tl_top.sv
module tl_top
  import tl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,

  // User command
  input  logic             usr_cmd_write_i,
  input  logic [31:0]      usr_cmd_addr_i,
  input  logic [3:0]       usr_cmd_be_i,
  input  logic [31:0]      usr_cmd_wdata_i,
  input  logic             usr_cmd_valid_i,
  output logic             usr_cmd_ready_o,

  // Link transmit
  output tl_hdr_u          tl_tx_o,
  output logic             tl_tx_valid_o,
  input  logic             tl_tx_ready_i,

  // Link receive
  input  tl_hdr_u          tl_rx_i,
  input  logic             tl_rx_valid_i,
  output logic             tl_rx_ready_o,

  // User read return
  output logic [TAG_W-1:0] usr_rtag_o,
  output logic [31:0]      usr_raddr_o,
  output logic [31:0]      usr_rdata_o,
  output logic             usr_rerr_o,
  output logic             usr_rvalid_o,
  input  logic             usr_rready_i
);

  // --------------------------------------------------------------------------
  // Tag table links
  // --------------------------------------------------------------------------

  logic             alloc_gnt;
  logic [TAG_W-1:0] alloc_tag;
  logic             alloc_req;
  logic [31:0]      alloc_addr;
  logic [TAG_W-1:0] lookup_tag;
  logic [31:0]      lookup_addr;
  logic             lookup_busy;
  logic             free_req;
  logic [TAG_W-1:0] free_tag;

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------

  // Request side, commands to TX beats
  tl_req_builder u_req_builder (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .usr_cmd_write_i (usr_cmd_write_i),
    .usr_cmd_addr_i  (usr_cmd_addr_i),
    .usr_cmd_be_i    (usr_cmd_be_i),
    .usr_cmd_wdata_i (usr_cmd_wdata_i),
    .usr_cmd_valid_i (usr_cmd_valid_i),
    .usr_cmd_ready_o (usr_cmd_ready_o),
    .tl_tx_o         (tl_tx_o),
    .tl_tx_valid_o   (tl_tx_valid_o),
    .tl_tx_ready_i   (tl_tx_ready_i),
    .alloc_gnt_i     (alloc_gnt),
    .alloc_tag_i     (alloc_tag),
    .alloc_req_o     (alloc_req),
    .alloc_addr_o    (alloc_addr)
  );

  // Outstanding reads
  tl_tag_table u_tag_table (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .alloc_req_i   (alloc_req),
    .alloc_addr_i  (alloc_addr),
    .alloc_gnt_o   (alloc_gnt),
    .alloc_tag_o   (alloc_tag),
    .lookup_tag_i  (lookup_tag),
    .lookup_addr_o (lookup_addr),
    .lookup_busy_o (lookup_busy),
    .free_req_i    (free_req),
    .free_tag_i    (free_tag)
  );

  // Completion side, RX beats to user results
  tl_cpl_decoder u_cpl_decoder (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .tl_rx_i       (tl_rx_i),
    .tl_rx_valid_i (tl_rx_valid_i),
    .tl_rx_ready_o (tl_rx_ready_o),
    .lookup_tag_o  (lookup_tag),
    .lookup_addr_i (lookup_addr),
    .lookup_busy_i (lookup_busy),
    .usr_rtag_o    (usr_rtag_o),
    .usr_raddr_o   (usr_raddr_o),
    .usr_rdata_o   (usr_rdata_o),
    .usr_rerr_o    (usr_rerr_o),
    .usr_rvalid_o  (usr_rvalid_o),
    .usr_rready_i  (usr_rready_i),
    .free_req_o    (free_req),
    .free_tag_o    (free_tag)
  );

endmodule

// File: verif/tl_asserts.sv
module tl_asserts
  import tl_pkg::*;
(
  input logic                clk,
  input logic                rst_n_i,
  input tl_hdr_u             tx_beat_i,
  input logic                tx_valid_i,
  input logic                tx_ready_i,
  input logic [TAG_W-1:0]    rtag_i,
  input logic [31:0]         raddr_i,
  input logic [31:0]         rdata_i,
  input logic                rerr_i,
  input logic                rvalid_i,
  input logic                rready_i,
  input logic [NUM_TAGS-1:0] busy_i,
  input logic                alloc_req_i,
  input logic                free_req_i,
  input logic [TAG_W-1:0]    free_tag_i
);

  int fail_cnt = 0;

  // Stalled TX beat stays put
  tx_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_beat_i))
    else begin
      fail_cnt++;
      $error("TX beat dropped or changed under stall");
    end

  // Stalled user result stays put
  rd_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable({rtag_i, raddr_i, rdata_i, rerr_i}))
    else begin
      fail_cnt++;
      $error("User read result dropped or changed under stall");
    end

  // No read may take a tag from a full table
  no_gnt_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    &busy_i |-> !alloc_req_i)
    else begin
      fail_cnt++;
      $error("Tag allocated while every tag is busy");
    end

  free_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    free_req_i |-> busy_i[free_tag_i])
    else begin
      fail_cnt++;
      $error("Free of a tag that is not busy");
    end

endmodule

bind tl_top tl_asserts u_tl_asserts (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .tx_beat_i   (tl_tx_o),
  .tx_valid_i  (tl_tx_valid_o),
  .tx_ready_i  (tl_tx_ready_i),
  .rtag_i      (usr_rtag_o),
  .raddr_i     (usr_raddr_o),
  .rdata_i     (usr_rdata_o),
  .rerr_i      (usr_rerr_o),
  .rvalid_i    (usr_rvalid_o),
  .rready_i    (usr_rready_i),
  .busy_i      (u_tag_table.busy_q),
  .alloc_req_i (alloc_req),
  .free_req_i  (free_req),
  .free_tag_i  (free_tag)
);

// File: verif/tl_tb.sv
module tl_tb
  import tl_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TXN    = 300;
  // Reads only and no completions, so the tag table fills up
  localparam int HOLD_CYC   = 40;
  localparam int WDOG_CYC   = 60 * NUM_TXN;

  logic             clk;
  logic             rst_n_i;
  logic             usr_cmd_write_i;
  logic [31:0]      usr_cmd_addr_i;
  logic [3:0]       usr_cmd_be_i;
  logic [31:0]      usr_cmd_wdata_i;
  logic             usr_cmd_valid_i;
  logic             usr_cmd_ready_o;
  tl_hdr_u          tl_tx_o;
  logic             tl_tx_valid_o;
  logic             tl_tx_ready_i;
  tl_hdr_u          tl_rx_i;
  logic             tl_rx_valid_i;
  logic             tl_rx_ready_o;
  logic [TAG_W-1:0] usr_rtag_o;
  logic [31:0]      usr_raddr_o;
  logic [31:0]      usr_rdata_o;
  logic             usr_rerr_o;
  logic             usr_rvalid_o;
  logic             usr_rready_i;

  integer seed;

  // --------------------------------------------------------------------------
  // Reference model state
  // --------------------------------------------------------------------------

  tl_hdr_u             tx_exp_q [$];
  logic [TAG_W-1:0]    rtag_exp_q [$];
  logic [31:0]         raddr_exp_q [$];
  logic [31:0]         rdata_exp_q [$];
  logic                rerr_exp_q [$];
  logic [NUM_TAGS-1:0] busy_mdl;
  logic [NUM_TAGS-1:0] cpl_sent;    // Completion already on its way
  logic [31:0]         addr_mdl [NUM_TAGS];
  logic [TAG_W-1:0]    rx_tag;
  logic [2:0]          rx_status;
  logic [31:0]         rx_data;
  int                  issued;
  int                  cyc;
  int                  blocked;
  bit                  cmd_pend;
  bit                  rx_pend;
  bit                  finished;
  // Transfers of the previous cycle, output due now
  bit                  cmd_seen;
  bit                  rx_seen;

  tl_top u_tl_top (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // Request beat as the request rules describe it
  function automatic tl_hdr_u make_req(input logic wr, input logic [31:0] addr,
                                       input logic [3:0] be, input logic [31:0] wdata,
                                       input logic [TAG_W-1:0] tag);
    tl_hdr_u b;
    b                  = '0;
    b.req.fmt          = wr ? FMT_3DW_DATA : FMT_3DW_NODATA;
    b.req.typ          = TYPE_MEM;
    b.req.length       = LEN_ONE_DW;
    b.req.requester_id = REQUESTER_ID;
    b.req.tag          = wr ? 8'h00 : 8'(tag);
    b.req.first_be     = be;
    b.req.addr_dw      = addr[31:2];
    b.req.data         = wr ? wdata : 32'h0;
    return b;
  endfunction

  // Completion beat as the link would send it
  function automatic tl_hdr_u make_cpl(input logic [TAG_W-1:0] tag,
                                       input logic [2:0] status,
                                       input logic [31:0] data);
    tl_hdr_u b;
    b                  = '0;
    b.cpl.fmt          = (status == CPL_STATUS_SC) ? FMT_3DW_DATA : FMT_3DW_NODATA;
    b.cpl.typ          = TYPE_CPL;
    b.cpl.length       = LEN_ONE_DW;
    b.cpl.completer_id = 16'h0200 + 16'(tag);
    b.cpl.status       = status;
    b.cpl.byte_count   = 12'd4;
    b.cpl.requester_id = REQUESTER_ID;
    b.cpl.tag          = 8'(tag);
    b.cpl.lower_addr   = addr_mdl[tag][6:0];
    // Error completions still carry junk data that must not reach the user
    b.cpl.data         = data;
    return b;
  endfunction

  function automatic logic [TAG_W-1:0] lowest_free();
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (!busy_mdl[i]) begin
        return TAG_W'(i);
      end
    end
    return '0;
  endfunction

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_tx(input tl_hdr_u exp_beat, input tl_hdr_u act_beat);
    if (act_beat !== exp_beat) begin
      $display("ERR tl_tx_o exp=%h act=%h", exp_beat, act_beat);
      stop_run();
    end
  endtask

  task automatic check_rd(input logic [TAG_W-1:0] tag, input logic [31:0] addr,
                          input logic [31:0] data, input logic err);
    if (usr_rtag_o !== tag) begin
      $display("ERR usr_rtag_o exp=%h act=%h", tag, usr_rtag_o);
      stop_run();
    end
    if (usr_raddr_o !== addr) begin
      $display("ERR usr_raddr_o exp=%h act=%h", addr, usr_raddr_o);
      stop_run();
    end
    if (usr_rdata_o !== data) begin
      $display("ERR usr_rdata_o exp=%h act=%h", data, usr_rdata_o);
      stop_run();
    end
    if (usr_rerr_o !== err) begin
      $display("ERR usr_rerr_o exp=%h act=%h", err, usr_rerr_o);
      stop_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Sample at the falling edge, all handshakes settled
  // --------------------------------------------------------------------------

  task automatic observe();
    logic             cmd_fire;
    logic             tx_fire;
    logic             rx_fire;
    logic             rd_fire;
    logic             rx_err;
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] free_tag;
    cmd_fire = usr_cmd_valid_i && usr_cmd_ready_o;
    tx_fire  = tl_tx_valid_o && tl_tx_ready_i;
    rx_fire  = tl_rx_valid_i && tl_rx_ready_o;
    rd_fire  = usr_rvalid_o && usr_rready_i;
    if (u_tl_top.u_tl_asserts.fail_cnt != 0) begin
      fail_run("A bound assertion on the top level failed");
    end
    // One cycle from command to beat and from completion to result
    if (cmd_seen && !tl_tx_valid_o) begin
      fail_run("No TX beat one cycle after a command transfer");
    end
    if (rx_seen && !usr_rvalid_o) begin
      fail_run("No user result one cycle after a completion transfer");
    end
    cmd_seen = cmd_fire;
    rx_seen  = rx_fire;
    // Full tag table must hold reads back
    if (usr_cmd_valid_i && !usr_cmd_write_i && (&busy_mdl)) begin
      if (usr_cmd_ready_o) begin
        fail_run("A read was accepted while all tags were busy");
      end
      blocked++;
    end
    if (rd_fire) begin
      if (rtag_exp_q.size() == 0) begin
        fail_run("A user read result appeared with none expected");
      end
      check_rd(rtag_exp_q[0], raddr_exp_q[0], rdata_exp_q[0], rerr_exp_q[0]);
      free_tag = rtag_exp_q.pop_front();
      void'(raddr_exp_q.pop_front());
      void'(rdata_exp_q.pop_front());
      void'(rerr_exp_q.pop_front());
    end
    if (tx_fire) begin
      if (tx_exp_q.size() == 0) begin
        fail_run("A TX beat was sent with none expected");
      end
      check_tx(tx_exp_q.pop_front(), tl_tx_o);
    end
    if (cmd_fire) begin
      if (usr_cmd_write_i) begin
        tx_exp_q.push_back(make_req(1'b1, usr_cmd_addr_i, usr_cmd_be_i,
                                    usr_cmd_wdata_i, '0));
      end else begin
        // Tag freed in this cycle is not yet visible
        tag           = lowest_free();
        busy_mdl[tag] = 1'b1;
        addr_mdl[tag] = {usr_cmd_addr_i[31:2], 2'b00};
        tx_exp_q.push_back(make_req(1'b0, usr_cmd_addr_i, usr_cmd_be_i,
                                    usr_cmd_wdata_i, tag));
      end
      issued++;
      cmd_pend = 1'b0;
    end
    if (rx_fire) begin
      rx_err = rx_status != CPL_STATUS_SC;
      rtag_exp_q.push_back(rx_tag);
      raddr_exp_q.push_back(addr_mdl[rx_tag]);
      rdata_exp_q.push_back(rx_err ? 32'h0 : rx_data);
      rerr_exp_q.push_back(rx_err);
      rx_pend = 1'b0;
    end
    if (rd_fire) begin
      busy_mdl[free_tag] = 1'b0;
      cpl_sent[free_tag] = 1'b0;
    end
    finished = (issued == NUM_TXN) && !cmd_pend && !rx_pend && (busy_mdl == '0) &&
               (tx_exp_q.size() == 0) && (rtag_exp_q.size() == 0);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus, just after the rising edge
  // --------------------------------------------------------------------------

  task automatic drive();
    logic [31:0]      r;
    logic [TAG_W-1:0] cand [$];
    // Random back-pressure on both outputs
    r             = next_rand();
    tl_tx_ready_i = r[1:0] != 2'b00;
    usr_rready_i  = r[3:2] != 2'b00;
    if (!cmd_pend) begin
      usr_cmd_valid_i = 1'b0;
      if (issued < NUM_TXN && r[5:4] != 2'b00) begin
        usr_cmd_write_i = (cyc < HOLD_CYC) ? 1'b0 : r[6];
        usr_cmd_addr_i  = next_rand();
        usr_cmd_be_i    = r[11:8];
        usr_cmd_wdata_i = next_rand();
        usr_cmd_valid_i = 1'b1;
        cmd_pend        = 1'b1;
      end
    end
    if (!rx_pend) begin
      tl_rx_valid_i = 1'b0;
      if (cyc >= HOLD_CYC && r[13:12] != 2'b00) begin
        for (int i = 0; i < NUM_TAGS; i++) begin
          if (busy_mdl[i] && !cpl_sent[i]) begin
            cand.push_back(TAG_W'(i));
          end
        end
        if (cand.size() > 0) begin
          rx_tag            = cand[next_rand() % cand.size()];
          // About one in four completions fails
          rx_status         = (r[15:14] != 2'b00) ? CPL_STATUS_SC :
                              (r[16] ? 3'b001 : 3'b100);
          rx_data           = next_rand();
          tl_rx_i           = make_cpl(rx_tag, rx_status, rx_data);
          tl_rx_valid_i     = 1'b1;
          cpl_sent[rx_tag]  = 1'b1;
          rx_pend           = 1'b1;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    seed            = 75613;
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    usr_cmd_write_i = 1'b0;
    usr_cmd_addr_i  = '0;
    usr_cmd_be_i    = '0;
    usr_cmd_wdata_i = '0;
    usr_cmd_valid_i = 1'b0;
    tl_tx_ready_i   = 1'b0;
    tl_rx_i         = '0;
    tl_rx_valid_i   = 1'b0;
    usr_rready_i    = 1'b0;
    busy_mdl        = '0;
    cpl_sent        = '0;
    issued          = 0;
    cyc             = 0;
    blocked         = 0;
    cmd_pend        = 1'b0;
    rx_pend         = 1'b0;
    finished        = 1'b0;
    cmd_seen        = 1'b0;
    rx_seen         = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    drive();
    while (!finished) begin
      @(negedge clk);
      observe();
      @(posedge clk);
      #2;
      cyc++;
      drive();
    end
    if (blocked == 0) begin
      fail_run("No read was ever held back by a full tag table");
    end else if (u_tl_top.u_tl_asserts.fail_cnt != 0) begin
      fail_run("A bound assertion on the top level failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  initial begin
    #(WDOG_CYC * CLK_PERIOD);
    fail_run("Timeout, the transactions did not all complete");
  end

endmodule

// File: vlog.f
logic/tl_pkg.sv
logic/tl_req_builder.sv
logic/tl_tag_table.sv
logic/tl_cpl_decoder.sv
logic/tl_top.sv
verif/tl_asserts.sv
verif/tl_tb.sv
